/* hdl/axis_in_config.svh */
`ifndef AXIS_IN_CONFIG_SVH
`define AXIS_IN_CONFIG_SVH

// Stream data width in bits
// Only 8 and 16 divide the 32-bit word evenly
`define AXIS_IN_TDATA_W 8

// FIFO depth in words, as log2
// 3 gives 8 words of 32 bits
`define AXIS_IN_FIFO_DEPTH_LOG2 3

// CPU address width, counted in words
`define AXIS_IN_ADDR_W 2

// Word address of the empty flag
`define AXIS_IN_EMPTY_ADDR 0

// Word address of the data output, reading it pops the FIFO
`define AXIS_IN_OUT_ADDR 1

// Word address of the last flag and byte strobe
`define AXIS_IN_LAST_ADDR 2

`endif

/* hdl/axis_in_pkg.sv */
package axis_in_pkg;

`include "axis_in_config.svh"

  // One stream beat as seen on the wires
  // tready travels the other way and stays a separate port
  typedef struct packed {
    logic [`AXIS_IN_TDATA_W-1:0] tdata;
    logic                        tvalid;
    logic                        tlast;
  } axis_beat_t;

  // One FIFO entry
  // Data is packed little-endian, strb marks valid bytes
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        last;
  } axis_word_t;

  // CPU request, zero wstrb means read
  typedef struct packed {
    logic                       avalid;
    logic [`AXIS_IN_ADDR_W-1:0] addr;
    logic [31:0]                wdata;
    logic [3:0]                 wstrb;
  } cpu_req_t;

  // CPU response, rdata qualified by rvalid
  typedef struct packed {
    logic        ready;
    logic        rvalid;
    logic [31:0] rdata;
  } cpu_rsp_t;

  // Decoded LAST register
  // Bit 4 is the frame end flag, bits 3:0 the byte strobe
  typedef struct packed {
    logic [26:0] pad;
    logic        last;
    logic [3:0]  strb;
  } last_status_t;

  // Same 32 bits, either as a bus word or as LAST fields
  typedef union packed {
    logic [31:0]  raw;
    last_status_t status;
  } reg_word_u;

endpackage

/* hdl/axis_in_packer.sv */
`timescale 1ns/1ns
`include "axis_in_config.svh"

module axis_in_packer
  import axis_in_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  axis_beat_t axis_i,
  output logic       tready_o,
  input  logic       full_i,
  input  logic       release_i,
  output logic       push_o,
  output axis_word_t word_o
);

  // Bytes per beat and beats per 32-bit word
  localparam int TDATA_W    = `AXIS_IN_TDATA_W;
  localparam int BEAT_BYTES = TDATA_W / 8;
  localparam int LANES      = 32 / TDATA_W;
  localparam int LANE_W     = $clog2(LANES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

  // Next beat position inside the word
  logic [LANE_W-1:0] lane;
  // Partial word and its filled bytes
  logic [31:0]       acc_data;
  logic [3:0]        acc_strb;
  // Set after TLAST until the CPU confirms the frame
  logic              frame_held;

  logic              beat_fire;
  logic              word_done;
  logic [31:0]       beat_data;
  logic [3:0]        beat_strb;
  logic [31:0]       next_data;
  logic [3:0]        next_strb;

  // Stall while a frame waits for the CPU, or while the FIFO is full
  assign tready_o  = !frame_held && !full_i;
  assign beat_fire = axis_i.tvalid && tready_o;

  // Word closes on the top lane or on frame end
  assign word_done = (lane == LAST_LANE) || axis_i.tlast;

  // Beat moved up to its lane
  assign beat_data = 32'(axis_i.tdata) << (int'(lane) * TDATA_W);
  assign beat_strb = 4'(((1 << BEAT_BYTES) - 1) << (int'(lane) * BEAT_BYTES));

  // Merge beat into partial word
  // Bytes not yet written read as zero, so TLAST padding comes for free
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (acc_strb[b]) begin
        next_data[8*b +: 8] = acc_data[8*b +: 8];
      end else if (beat_strb[b]) begin
        next_data[8*b +: 8] = beat_data[8*b +: 8];
      end else begin
        next_data[8*b +: 8] = 8'h00;
      end
    end
    next_strb = acc_strb | beat_strb;
  end

  // Completed word goes straight to the FIFO in the beat's own cycle
  assign push_o      = beat_fire && word_done;
  assign word_o.data = next_data;
  assign word_o.strb = next_strb;
  assign word_o.last = axis_i.tlast;

  // Lane index, byte strobe and frame hold
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lane       <= '0;
      acc_strb   <= '0;
      frame_held <= 1'b0;
    end else begin
      if (beat_fire) begin
        if (word_done) begin
          // Start a fresh word, lane 0 again
          lane     <= '0;
          acc_strb <= '0;
        end else begin
          lane     <= lane + 1'b1;
          acc_strb <= next_strb;
        end
      end
      // Hold after TLAST
      if (beat_fire && axis_i.tlast) begin
        frame_held <= 1'b1;
      end else if (release_i) begin
        frame_held <= 1'b0;
      end
    end
  end

  // Partial word bytes, only meaningful where acc_strb is set
  always_ff @(posedge clk_i) begin
    if (beat_fire && !word_done) begin
      acc_data <= next_data;
    end
  end

endmodule

/* hdl/axis_in_fifo.sv */
`timescale 1ns/1ns
`include "axis_in_config.svh"

module axis_in_fifo
  import axis_in_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Write side, from the packer
  input  logic       push_i,
  input  axis_word_t word_i,
  output logic       full_o,
  // Read side, from the register block
  input  logic       pop_i,
  output axis_word_t rd_word_o,
  output logic       empty_o
);

  localparam int DEPTH_LOG2 = `AXIS_IN_FIFO_DEPTH_LOG2;
  localparam int DEPTH      = 1 << DEPTH_LOG2;

  // Two-port word storage
  axis_word_t mem [DEPTH];

  // Pointers carry one extra wrap bit
  logic [DEPTH_LOG2:0]   wr_ptr;
  logic [DEPTH_LOG2:0]   rd_ptr;
  logic [DEPTH_LOG2-1:0] wr_addr;
  logic [DEPTH_LOG2-1:0] rd_addr;
  logic                  wrap_diff;

  // Accepted operations only
  logic                  do_push;
  logic                  do_pop;

  assign wr_addr   = wr_ptr[DEPTH_LOG2-1:0];
  assign rd_addr   = rd_ptr[DEPTH_LOG2-1:0];
  assign wrap_diff = wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2];

  // Same address, same lap: empty
  assign empty_o = !wrap_diff && (wr_addr == rd_addr);
  // Same address, writer one lap ahead: full
  assign full_o  = wrap_diff && (wr_addr == rd_addr);

  // Push when full and pop when empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointer update
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage write port
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_addr] <= word_i;
    end
  end

  // Registered read port
  // Data shows one cycle after the pop and holds until the next one
  always_ff @(posedge clk_i) begin
    if (do_pop) begin
      rd_word_o <= mem[rd_addr];
    end
  end

endmodule

/* hdl/axis_in_regs.sv */
`timescale 1ns/1ns
`include "axis_in_config.svh"

module axis_in_regs
  import axis_in_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  cpu_req_t   cpu_req_i,
  output cpu_rsp_t   cpu_rsp_o,
  input  logic       empty_i,
  input  axis_word_t rd_word_i,
  output logic       pop_o,
  output logic       release_o
);

  localparam int ADDR_W = `AXIS_IN_ADDR_W;
  localparam logic [ADDR_W-1:0] EMPTY_ADDR = ADDR_W'(`AXIS_IN_EMPTY_ADDR);
  localparam logic [ADDR_W-1:0] OUT_ADDR   = ADDR_W'(`AXIS_IN_OUT_ADDR);
  localparam logic [ADDR_W-1:0] LAST_ADDR  = ADDR_W'(`AXIS_IN_LAST_ADDR);

  // Request decode
  logic              rd_req;
  logic              sel_last;
  // Response state, one cycle behind the request
  logic              rvalid_q;
  logic [ADDR_W-1:0] addr_q;
  logic              popped_q;
  logic              empty_q;
  reg_word_u         last_rsp_q;
  // Status of the most recently popped word
  reg_word_u         saved_q;
  reg_word_u         status_now;

  // Reads only, writes are taken and dropped
  assign rd_req   = cpu_req_i.avalid && (cpu_req_i.wstrb == 4'h0);
  assign sel_last = cpu_req_i.addr == LAST_ADDR;

  // OUT read pops unless there is nothing to pop
  assign pop_o = rd_req && (cpu_req_i.addr == OUT_ADDR) && !empty_i;

  // Word popped last cycle overrides the record
  // so a LAST read right behind an OUT read sees it
  always_comb begin
    status_now = saved_q;
    if (popped_q) begin
      status_now.status.pad  = '0;
      status_now.status.last = rd_word_i.last;
      status_now.status.strb = rd_word_i.strb;
    end
  end

  // Frame fully drained and confirmed
  assign release_o = rd_req && sel_last && empty_i && status_now.status.last;

  // Control side of the response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q    <= 1'b0;
      addr_q      <= EMPTY_ADDR;
      popped_q    <= 1'b0;
      empty_q     <= 1'b1;
      saved_q.raw <= '0;
    end else begin
      rvalid_q <= rd_req;
      popped_q <= pop_o;
      if (rd_req) begin
        addr_q  <= cpu_req_i.addr;
        empty_q <= empty_i;
      end
      // Clear on release, else capture the popped word
      if (release_o) begin
        saved_q.raw <= '0;
      end else if (popped_q) begin
        saved_q <= status_now;
      end
    end
  end

  // LAST value as it stood when read
  always_ff @(posedge clk_i) begin
    if (rd_req && sel_last) begin
      last_rsp_q <= status_now;
    end
  end

  // Response mux
  always_comb begin
    cpu_rsp_o.ready  = 1'b1;
    cpu_rsp_o.rvalid = rvalid_q;
    case (addr_q)
      EMPTY_ADDR: cpu_rsp_o.rdata = {31'b0, empty_q};
      OUT_ADDR:   cpu_rsp_o.rdata = popped_q ? rd_word_i.data : 32'h0; // 0 when read empty
      LAST_ADDR:  cpu_rsp_o.rdata = last_rsp_q.raw;
      default:    cpu_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule

/* hdl/axis_in_top.sv */
`timescale 1ns/1ns

module axis_in_top
  import axis_in_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Stream input
  input  axis_beat_t axis_i,
  output logic       axis_tready_o,
  // CPU register bus
  input  cpu_req_t   cpu_req_i,
  output cpu_rsp_t   cpu_rsp_o
);

  // Packer to FIFO
  logic       push;
  axis_word_t push_word;
  logic       full;
  // FIFO to register block
  logic       pop;
  axis_word_t rd_word;
  logic       empty;
  // Register block back to packer
  logic       frame_release;

  // Producer, beats into words
  axis_in_packer u_packer (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .axis_i    (axis_i),
    .tready_o  (axis_tready_o),
    .full_i    (full),
    .release_i (frame_release),
    .push_o    (push),
    .word_o    (push_word)
  );

  // Word buffer
  axis_in_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .push_i    (push),
    .word_i    (push_word),
    .full_o    (full),
    .pop_i     (pop),
    .rd_word_o (rd_word),
    .empty_o   (empty)
  );

  // Consumer, CPU side
  axis_in_regs u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_o (cpu_rsp_o),
    .empty_i   (empty),
    .rd_word_i (rd_word),
    .pop_o     (pop),
    .release_o (frame_release)
  );

endmodule

/* tb/axis_in_chk.sv */
`timescale 1ns/1ns
`include "axis_in_config.svh"

module axis_in_chk
  import axis_in_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input axis_beat_t axis_i,
  input logic       tready_i,
  input logic       release_i,
  input logic       push_i,
  input logic       pop_i,
  input cpu_req_t   cpu_req_i,
  input cpu_rsp_t   cpu_rsp_i
);

  localparam int DEPTH = 1 << `AXIS_IN_FIFO_DEPTH_LOG2;

  // Count of failed assertions, watched from the testbench
  int unsigned fail_cnt = 0;
  logic        rd_req;
  // Frame end seen on the stream and not yet released by the CPU
  logic        held_q;
  // FIFO words, counted from push and pop alone
  int          level;

  // Read request as the register block decodes it
  assign rd_req = cpu_req_i.avalid && (cpu_req_i.wstrb == 4'h0);

  // Hold and fill level as the stream and bus handshakes imply them
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q <= 1'b0;
      level  <= 0;
    end else begin
      if (axis_i.tvalid && tready_i && axis_i.tlast) begin
        held_q <= 1'b1;
      end else if (release_i) begin
        held_q <= 1'b0;
      end
      level <= level + int'(push_i && (level < DEPTH)) - int'(pop_i && (level > 0));
    end
  end

  // Stream stays stalled while a frame waits for the CPU
  held_stalls_stream: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    held_q |-> !tready_i)
    else begin
      fail_cnt++;
      $error("tready high while the packer holds a frame");
    end

  // Packer never pushes into a full FIFO
  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (level < DEPTH))
    else begin
      fail_cnt++;
      $error("push into a full FIFO");
    end

  // Read data comes back exactly one cycle after the request
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_req |=> cpu_rsp_i.rvalid)
    else begin
      fail_cnt++;
      $error("rvalid missing one cycle after a read");
    end

  // And never without one
  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !rd_req |=> !cpu_rsp_i.rvalid)
    else begin
      fail_cnt++;
      $error("rvalid without a read request");
    end

endmodule

/* tb/axis_in_tb.sv */
`timescale 1ns/1ns
`include "axis_in_config.svh"

module axis_in_tb
  import axis_in_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int BEAT_BYTES = `AXIS_IN_TDATA_W / 8;
  localparam int FIFO_DEPTH = 1 << `AXIS_IN_FIFO_DEPTH_LOG2;
  localparam int ADDR_W     = `AXIS_IN_ADDR_W;
  localparam int RND_FRAMES = 16;
  localparam int SEED       = 96645;
  // Bytes of the directed frames, for the watchdog budget
  localparam int FIXED_BYTES = 12 + 1 + 2 + 3 + 5 + 6 + 7 + FIFO_DEPTH * 4 + 8;
  localparam logic [ADDR_W-1:0] EMPTY_ADDR = ADDR_W'(`AXIS_IN_EMPTY_ADDR);
  localparam logic [ADDR_W-1:0] OUT_ADDR   = ADDR_W'(`AXIS_IN_OUT_ADDR);
  localparam logic [ADDR_W-1:0] LAST_ADDR  = ADDR_W'(`AXIS_IN_LAST_ADDR);

  typedef logic [7:0] byte_q_t[$];
  typedef axis_word_t word_q_t[$];

  logic       clk;
  logic       rst_n;
  axis_beat_t axis;
  logic       tready;
  cpu_req_t   cpu_req;
  cpu_rsp_t   cpu_rsp;

  // Expected words, and words read back with their LAST word
  axis_word_t exp_q[$];
  axis_word_t got_q[$];
  reg_word_u  stat_q[$];
  string      test_name;

  axis_in_top dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .axis_i        (axis),
    .axis_tready_o (tready),
    .cpu_req_i     (cpu_req),
    .cpu_rsp_o     (cpu_rsp)
  );

  bind axis_in_top axis_in_chk u_chk (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .axis_i    (axis_i),
    .tready_i  (axis_tready_o),
    .release_i (frame_release),
    .push_i    (push),
    .pop_i     (pop),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_i (cpu_rsp_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_word(input string name, input axis_word_t exp, input axis_word_t act);
    if (exp !== act) begin
      $display("** Error %s: expected data=%h strb=%h last=%b, actual data=%h strb=%h last=%b",
               name, exp.data, exp.strb, exp.last, act.data, act.strb, act.last);
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input last_status_t exp,
                              input last_status_t act);
    if (exp !== act) begin
      $display("** Error %s: expected LAST=%h, actual LAST=%h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected flag=%b, actual flag=%b", name, exp, act);
      abort_run();
    end
  endtask

  // Reference packing, little-endian, last word padded with zeros
  function automatic word_q_t pack_frame(input byte_q_t bytes);
    word_q_t    words;
    axis_word_t w;
    int         lane;
    w = '0;
    lane = 0;
    foreach (bytes[i]) begin
      w.data[8*lane +: 8] = bytes[i];
      w.strb[lane] = 1'b1;
      lane++;
      if (lane == 4 || i == bytes.size() - 1) begin
        w.last = (i == bytes.size() - 1);
        words.push_back(w);
        w = '0;
        lane = 0;
      end
    end
    return words;
  endfunction

  // Length rounded up to whole beats
  function automatic byte_q_t make_frame(input int len, input bit rnd);
    byte_q_t bytes;
    int      n;
    n = ((len + BEAT_BYTES - 1) / BEAT_BYTES) * BEAT_BYTES;
    for (int i = 0; i < n; i++) begin
      if (rnd) begin
        bytes.push_back(8'($urandom_range(255)));
      end else begin
        bytes.push_back(8'(i * 37 + len));
      end
    end
    return bytes;
  endfunction

  task automatic load_expected(input byte_q_t bytes);
    word_q_t words;
    words = pack_frame(bytes);
    foreach (words[i]) exp_q.push_back(words[i]);
  endtask

  // One beat per loop, held until tready was seen high
  task automatic send_frame(input byte_q_t bytes, input int gap_max);
    int nbeats;
    nbeats = bytes.size() / BEAT_BYTES;
    for (int b = 0; b < nbeats; b++) begin
      repeat ($urandom_range(gap_max)) begin
        axis.tvalid = 1'b0;
        @(negedge clk);
      end
      for (int k = 0; k < BEAT_BYTES; k++) axis.tdata[8*k +: 8] = bytes[b*BEAT_BYTES + k];
      axis.tvalid = 1'b1;
      axis.tlast  = (b == nbeats - 1);
      while (!tready) @(negedge clk);
      @(negedge clk);
    end
    axis.tvalid = 1'b0;
    axis.tlast  = 1'b0;
  endtask

  task automatic cpu_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    cpu_req.avalid = 1'b1;
    cpu_req.addr   = addr;
    cpu_req.wstrb  = 4'h0;
    @(negedge clk);
    cpu_req.avalid = 1'b0;
    while (!cpu_rsp.rvalid) @(negedge clk);
    data = cpu_rsp.rdata;
    // The bus never stalls a request
    check_flag(test_name, 1'b1, cpu_rsp.ready);
  endtask

  // Poll EMPTY, then OUT and LAST per word, up to the frame end
  task automatic drain_frame(input int gap_max);
    logic [31:0] rd;
    reg_word_u   st;
    axis_word_t  w;
    bit          done;
    done = 1'b0;
    while (!done) begin
      repeat ($urandom_range(gap_max)) @(negedge clk);
      cpu_read(EMPTY_ADDR, rd);
      if (rd[0] == 1'b0) begin
        cpu_read(OUT_ADDR, rd);
        cpu_read(LAST_ADDR, st.raw);
        w.data = rd;
        w.strb = st.status.strb;
        w.last = st.status.last;
        got_q.push_back(w);
        stat_q.push_back(st);
        done = st.status.last;
      end
    end
  endtask

  task automatic wait_compare();
    while (got_q.size() != 0) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected words were never read", test_name, exp_q.size());
      abort_run();
    end
  endtask

  task automatic run_frame(input byte_q_t bytes, input int beat_gap, input int read_gap);
    load_expected(bytes);
    fork
      send_frame(bytes, beat_gap);
      drain_frame(read_gap);
    join
    wait_compare();
  endtask

  // Compares every word read back against the reference queue
  always @(negedge clk) begin : compare_words
    axis_word_t   exp;
    last_status_t exp_st;
    reg_word_u    st;
    if (got_q.size() != 0) begin
      st = stat_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("%s: a word was read that no frame should have produced", test_name);
        abort_run();
      end else begin
        exp = exp_q.pop_front();
        exp_st = '0;
        exp_st.last = exp.last;
        exp_st.strb = exp.strb;
        check_word(test_name, exp, got_q.pop_front());
        check_status(test_name, exp_st, st.status);
      end
    end
  end

  always @(negedge clk) begin
    if (dut.u_chk.fail_cnt != 0) begin
      $display("A handshake assertion in the bound checker failed");
      abort_run();
    end
  end

  initial begin
    byte_q_t     bytes;
    logic [31:0] rd;
    reg_word_u   st;
    axis_word_t  w;
    int          tail_len[4];
    int          rnd_len[RND_FRAMES];
    longint      total_bytes;
    longint      limit_ns;
    clk = 1'b0;
    rst_n = 1'b0;
    axis = '0;
    cpu_req = '0;
    void'($urandom(SEED));
    total_bytes = FIXED_BYTES;
    foreach (rnd_len[i]) begin
      rnd_len[i] = $urandom_range(40, 1);
      total_bytes += rnd_len[i];
    end
    // Budget of 40 cycles per byte, plus reset and idle margin
    limit_ns = (total_bytes * 40 + 400) * CLK_PERIOD;
    fork
      begin
        #(limit_ns);
        $display("Timeout after %0d ns, the DUT stopped answering", limit_ns);
        abort_run();
      end
    join_none
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_name = "reset_state";
    check_flag(test_name, 1'b1, tready);
    cpu_read(EMPTY_ADDR, rd);
    check_flag(test_name, 1'b1, rd[0]);
    cpu_read(OUT_ADDR, rd);
    cpu_read(LAST_ADDR, st.raw);
    w.data = rd;
    w.strb = st.status.strb;
    w.last = st.status.last;
    check_word(test_name, '0, w);

    test_name = "full_words";
    run_frame(make_frame(12, 1'b0), 0, 0);

    test_name = "padded_tail";
    tail_len = '{1, 2, 3, 5};
    foreach (tail_len[i]) begin
      run_frame(make_frame(tail_len[i], 1'b0), 1, 1);
    end

    // Stream held after TLAST until LAST confirms the drain
    test_name = "hold_after_last";
    bytes = make_frame(6, 1'b0);
    load_expected(bytes);
    send_frame(bytes, 0);
    repeat (4) @(negedge clk);
    check_flag(test_name, 1'b0, tready);
    drain_frame(0);
    wait_compare();
    check_flag(test_name, 1'b1, tready);
    run_frame(make_frame(7, 1'b1), 1, 2);

    // Frame larger than the FIFO, reading starts only once it is full
    test_name = "back_pressure";
    bytes = make_frame(FIFO_DEPTH * 4 + 8, 1'b0);
    load_expected(bytes);
    fork
      send_frame(bytes, 0);
      begin
        repeat (FIFO_DEPTH * 4 / BEAT_BYTES + 4) @(negedge clk);
        check_flag(test_name, 1'b0, tready);
        cpu_read(EMPTY_ADDR, rd);
        check_flag(test_name, 1'b0, rd[0]);
        drain_frame(1);
      end
    join
    wait_compare();

    test_name = "random_frames";
    foreach (rnd_len[i]) run_frame(make_frame(rnd_len[i], 1'b1), 3, 5);

    repeat (4) @(negedge clk);
    if (exp_q.size() == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("Run ended with unchecked words or failed assertions");
      abort_run();
    end
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/axis_in_pkg.sv
hdl/axis_in_packer.sv
hdl/axis_in_fifo.sv
hdl/axis_in_regs.sv
hdl/axis_in_top.sv
tb/axis_in_chk.sv
tb/axis_in_tb.sv

/* Makefile */
# Verilator flow for the AXI-Stream input peripheral
VERILATOR ?= verilator
TOP       ?= axis_in_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
